/* dma_xif_pkg.sv */
// Covers a 32-bit register front end with 2-D transfers only; addresses follow a reg32 layout.
package dma_xif_pkg;

  localparam int unsigned DATA_W    = 32;              // Register and operand width.
  localparam int unsigned ADDR_W    = 32;              // Front-end address width.
  localparam int unsigned INSTR_W   = 32;
  localparam int unsigned N_RS      = 3;               // Source operands per instruction.
  localparam int unsigned N_CFG_REG = 7;               // Shadow registers without the 3-D set.
  localparam int unsigned STRB_W    = DATA_W / 8;
  localparam int unsigned IDX_W     = $clog2(N_CFG_REG);

  localparam int unsigned OPCODE_OFF = 0;
  localparam int unsigned OPCODE_W   = 7;
  localparam int unsigned FUNC3_OFF  = 12;
  localparam int unsigned FUNC3_W    = 3;

  // The configuration field sits above func3. From its LSB upwards it holds decouple aw,
  // decouple rw, src reduce length (2), dst reduce length (2), src max log length (3),
  // dst max log length (3) and the n-d enable bit.
  localparam int unsigned CONF_LSB = 15;
  localparam int unsigned CONF_W   = 13;

  localparam logic [OPCODE_W-1:0] CONF_OPCODE = 7'b1011011;  // custom-2 space.
  localparam logic [OPCODE_W-1:0] SET_OPCODE  = 7'b1111011;  // custom-3 space.

  localparam logic [FUNC3_W-1:0] CONF_FUNC3    = 3'b000;
  localparam logic [FUNC3_W-1:0] SET_AL_FUNC3  = 3'b000;   // Address and length.
  localparam logic [FUNC3_W-1:0] SET_SR2_FUNC3 = 3'b001;   // Strides and repeats, 2nd dim.
  localparam logic [FUNC3_W-1:0] SET_S_FUNC3   = 3'b011;   // Start the transfer.

  // Register indices double as the write priority, lowest first.
  localparam int unsigned IDX_CONF         = 0;
  localparam int unsigned IDX_DST_ADDR     = 1;
  localparam int unsigned IDX_SRC_ADDR     = 2;
  localparam int unsigned IDX_LENGTH       = 3;
  localparam int unsigned IDX_DST_STRIDE_2 = 4;
  localparam int unsigned IDX_SRC_STRIDE_2 = 5;
  localparam int unsigned IDX_REPS_2       = 6;

  // Front-end register offsets, ordered by register index.
  localparam logic [ADDR_W-1:0] FE_ADDR [N_CFG_REG] = '{
    32'h0000_0000,                                     // Configuration.
    32'h0000_00D0,                                     // Destination address.
    32'h0000_00D8,                                     // Source address.
    32'h0000_00E0,                                     // Length.
    32'h0000_00E8,                                     // Destination stride.
    32'h0000_00F0,                                     // Source stride.
    32'h0000_00F8                                      // Repetitions.
  };

  localparam logic [ADDR_W-1:0] FE_NEXT_ID_ADDR = 32'h0000_0044;
  localparam logic [ADDR_W-1:0] FE_DONE_ID_ADDR = 32'h0000_0084;

  // Issued instruction together with its source operands.
  typedef struct packed {
    logic [INSTR_W-1:0]          instr;
    logic [N_RS-1:0][DATA_W-1:0] rs;
    logic                        rs_valid;
  } issue_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              valid;
  } fe_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ready;
    logic              error;
  } fe_rsp_t;

  // One load bit and one value per shadow register.
  typedef struct packed {
    logic [N_CFG_REG-1:0]             load;
    logic [N_CFG_REG-1:0][DATA_W-1:0] value;
  } cfg_load_t;

endpackage

/* dma_cmd_decoder.sv */
// Purely combinational; a set opcode with an unknown func3 is accepted and has no effect.
`timescale 1ns/1ns

module dma_cmd_decoder (
  input  logic                    issue_valid_i,
  input  dma_xif_pkg::issue_req_t issue_req_i,
  output logic                    issue_ready_o,
  output logic                    issue_accept_o,
  output dma_xif_pkg::cfg_load_t  load_o,
  output logic                    start_req_o
);

  logic [dma_xif_pkg::OPCODE_W-1:0] opcode;
  logic [dma_xif_pkg::FUNC3_W-1:0]  func3;
  logic [dma_xif_pkg::DATA_W-1:0]   conf_word;
  logic                             is_conf;
  logic                             is_set;

  assign opcode = issue_req_i.instr[dma_xif_pkg::OPCODE_OFF +: dma_xif_pkg::OPCODE_W];
  assign func3  = issue_req_i.instr[dma_xif_pkg::FUNC3_OFF +: dma_xif_pkg::FUNC3_W];

  // The configuration bit fields are packed into the low bits of one register.
  assign conf_word = {{(dma_xif_pkg::DATA_W - dma_xif_pkg::CONF_W){1'b0}},
                      issue_req_i.instr[dma_xif_pkg::CONF_LSB +: dma_xif_pkg::CONF_W]};

  assign is_conf = (opcode == dma_xif_pkg::CONF_OPCODE) && (func3 == dma_xif_pkg::CONF_FUNC3);
  assign is_set  = (opcode == dma_xif_pkg::SET_OPCODE);

  assign issue_ready_o  = issue_valid_i & (is_conf | is_set);  // Consumed when valid and ready.
  assign issue_accept_o = issue_ready_o;                       // Nothing is written back.

  // Operands map as rs[2] destination, rs[1] source, rs[0] length or repetitions.
  always_comb begin
    load_o      = '0;
    start_req_o = 1'b0;
    if (issue_ready_o) begin
      if (is_conf) begin
        load_o.load[dma_xif_pkg::IDX_CONF]  = 1'b1;
        load_o.value[dma_xif_pkg::IDX_CONF] = conf_word;
      end else begin
        case (func3)
          dma_xif_pkg::SET_AL_FUNC3: begin
            if (issue_req_i.rs_valid) begin
              load_o.load[dma_xif_pkg::IDX_DST_ADDR]  = 1'b1;
              load_o.load[dma_xif_pkg::IDX_SRC_ADDR]  = 1'b1;
              load_o.load[dma_xif_pkg::IDX_LENGTH]    = 1'b1;
              load_o.value[dma_xif_pkg::IDX_DST_ADDR] = issue_req_i.rs[2];
              load_o.value[dma_xif_pkg::IDX_SRC_ADDR] = issue_req_i.rs[1];
              load_o.value[dma_xif_pkg::IDX_LENGTH]   = issue_req_i.rs[0];
            end
          end
          dma_xif_pkg::SET_SR2_FUNC3: begin
            if (issue_req_i.rs_valid) begin
              load_o.load[dma_xif_pkg::IDX_DST_STRIDE_2]  = 1'b1;
              load_o.load[dma_xif_pkg::IDX_SRC_STRIDE_2]  = 1'b1;
              load_o.load[dma_xif_pkg::IDX_REPS_2]        = 1'b1;
              load_o.value[dma_xif_pkg::IDX_DST_STRIDE_2] = issue_req_i.rs[2];
              load_o.value[dma_xif_pkg::IDX_SRC_STRIDE_2] = issue_req_i.rs[1];
              load_o.value[dma_xif_pkg::IDX_REPS_2]       = issue_req_i.rs[0];
            end
          end
          dma_xif_pkg::SET_S_FUNC3: begin
            start_req_o = 1'b1;                  // One cycle, since the instruction is consumed.
          end
          default: begin
            start_req_o = 1'b0;
          end
        endcase
      end
    end
  end

endmodule

/* dma_reg_configurer.sv */
// Writes start only in a cycle without new loads, so back-to-back set instructions go out in index order.
`timescale 1ns/1ns

module dma_reg_configurer (
  input  logic                   clk_dc_g,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  dma_xif_pkg::cfg_load_t load_i,
  input  logic                   tfr_idle_i,
  output dma_xif_pkg::fe_req_t   fe_req_o,
  input  dma_xif_pkg::fe_rsp_t   fe_rsp_i,
  output logic                   wr_error_o
);

  logic [dma_xif_pkg::DATA_W-1:0]    shadow_q [dma_xif_pkg::N_CFG_REG];
  logic [dma_xif_pkg::N_CFG_REG-1:0] pend_q;
  logic [dma_xif_pkg::N_CFG_REG-1:0] pend_d;
  logic [dma_xif_pkg::N_CFG_REG-1:0] done_mask;
  logic [dma_xif_pkg::IDX_W-1:0]     next_idx;
  logic [dma_xif_pkg::IDX_W-1:0]     sel_q;
  logic                              req_valid_q;
  logic [dma_xif_pkg::ADDR_W-1:0]    req_addr_q;
  logic [dma_xif_pkg::DATA_W-1:0]    req_data_q;
  logic                              launch;
  logic                              ack;

  // Lowest pending index wins.
  always_comb begin
    next_idx = '0;
    for (int i = dma_xif_pkg::N_CFG_REG - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        next_idx = i[dma_xif_pkg::IDX_W-1:0];
      end
    end
  end

  assign launch = ~req_valid_q & tfr_idle_i & (|pend_q) & ~(|load_i.load);
  assign ack    = req_valid_q & fe_rsp_i.ready;  // Response is zero while the port is taken.

  assign wr_error_o = ack & fe_rsp_i.error;

  // A failed write keeps its flag and is launched again.
  always_comb begin
    done_mask = '0;
    if (ack && !fe_rsp_i.error) begin
      done_mask[sel_q] = 1'b1;
    end
  end

  assign pend_d = (pend_q & ~done_mask) | load_i.load;  // A reload keeps the flag set.

  always_ff @(posedge clk_dc_g) begin
    for (int i = 0; i < dma_xif_pkg::N_CFG_REG; i++) begin
      if (load_i.load[i]) begin
        shadow_q[i] <= load_i.value[i];
      end
    end
  end

  always_ff @(posedge clk_dc_g or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q      <= '0;
      req_valid_q <= 1'b0;
    end else if (clear_i) begin
      pend_q      <= '0;
      req_valid_q <= 1'b0;                       // Drops a write still waiting for ready.
    end else begin
      pend_q <= pend_d;
      if (launch) begin
        req_valid_q <= 1'b1;
      end else if (ack) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  // The request is captured so it stays stable while the front end stalls.
  always_ff @(posedge clk_dc_g) begin
    if (launch) begin
      sel_q      <= next_idx;
      req_addr_q <= dma_xif_pkg::FE_ADDR[next_idx];
      req_data_q <= shadow_q[next_idx];
    end
  end

  assign fe_req_o = '{
    addr:  req_addr_q,
    write: 1'b1,
    wdata: req_data_q,
    wstrb: '1,                                   // Full register writes only.
    valid: req_valid_q
  };

endmodule

/* dma_transfer_ctrl.sv */
// A failed done-id poll flags an error and polls again; a start request outside IDLE is dropped.
`timescale 1ns/1ns

module dma_transfer_ctrl (
  input  logic                 clk_dc_g,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_req_i,
  input  dma_xif_pkg::fe_req_t cfg_fe_req_i,
  output dma_xif_pkg::fe_rsp_t cfg_fe_rsp_o,
  output logic                 tfr_idle_o,
  output dma_xif_pkg::fe_req_t fe_req_o,
  input  dma_xif_pkg::fe_rsp_t fe_rsp_i,
  output logic                 start_o,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 tfr_error_o
);

  typedef enum logic [1:0] {
    IDLE,
    START,
    BUSY,
    DONE
  } state_e;

  state_e                         state_q;
  state_e                         state_d;
  logic [dma_xif_pkg::DATA_W-1:0] next_id_q;
  logic [dma_xif_pkg::DATA_W-1:0] next_id_d;
  dma_xif_pkg::fe_req_t           own_req;

  always_comb begin
    state_d     = state_q;
    next_id_d   = next_id_q;
    own_req     = '0;                            // Reads carry no data and no strobes.
    start_o     = 1'b0;
    busy_o      = 1'b0;
    done_o      = 1'b0;
    tfr_error_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_req_i) begin
          state_d = START;
        end
      end
      START: begin
        start_o       = 1'b1;
        own_req.addr  = dma_xif_pkg::FE_NEXT_ID_ADDR;
        own_req.valid = 1'b1;
        if (fe_rsp_i.ready) begin
          if (fe_rsp_i.error || fe_rsp_i.rdata == '0) begin
            tfr_error_o = 1'b1;                  // Id zero means the transfer was not set up.
            state_d     = IDLE;
          end else begin
            next_id_d = fe_rsp_i.rdata;
            state_d   = BUSY;
          end
        end
      end
      BUSY: begin
        busy_o        = 1'b1;
        own_req.addr  = dma_xif_pkg::FE_DONE_ID_ADDR;
        own_req.valid = 1'b1;
        if (fe_rsp_i.ready) begin
          if (fe_rsp_i.error) begin
            tfr_error_o = 1'b1;
          end else if (fe_rsp_i.rdata == next_id_q) begin
            state_d = DONE;
          end
        end
      end
      DONE: begin
        done_o  = 1'b1;
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_dc_g or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      next_id_q <= 'd1;
    end else if (clear_i) begin
      state_q   <= IDLE;
      next_id_q <= 'd1;
    end else begin
      state_q   <= state_d;
      next_id_q <= next_id_d;
    end
  end

  // The configurer only sees the port while no transfer runs.
  assign tfr_idle_o   = (state_q == IDLE);
  assign fe_req_o     = tfr_idle_o ? cfg_fe_req_i : own_req;
  assign cfg_fe_rsp_o = tfr_idle_o ? fe_rsp_i : '0;

endmodule

/* dma_xif_decoder_top.sv */
// Single clock domain; error_o pulses for a failed write, a failed id read or a zero next id.
`timescale 1ns/1ns

module dma_xif_decoder_top (
  input  logic                    clk_dc_g,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    issue_valid_i,
  input  dma_xif_pkg::issue_req_t issue_req_i,
  output logic                    issue_ready_o,
  output logic                    issue_accept_o,
  output dma_xif_pkg::fe_req_t    fe_req_o,
  input  dma_xif_pkg::fe_rsp_t    fe_rsp_i,
  output logic                    start_o,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    error_o
);

  dma_xif_pkg::cfg_load_t cfg_load;
  dma_xif_pkg::fe_req_t   cfg_fe_req;
  dma_xif_pkg::fe_rsp_t   cfg_fe_rsp;
  logic                   start_req;
  logic                   tfr_idle;
  logic                   wr_error;
  logic                   tfr_error;

  dma_cmd_decoder i_cmd_decoder (
    .issue_valid_i  (issue_valid_i),
    .issue_req_i    (issue_req_i),
    .issue_ready_o  (issue_ready_o),
    .issue_accept_o (issue_accept_o),
    .load_o         (cfg_load),
    .start_req_o    (start_req)
  );

  dma_reg_configurer i_reg_configurer (
    .clk_dc_g   (clk_dc_g),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .load_i     (cfg_load),
    .tfr_idle_i (tfr_idle),
    .fe_req_o   (cfg_fe_req),
    .fe_rsp_i   (cfg_fe_rsp),
    .wr_error_o (wr_error)
  );

  dma_transfer_ctrl i_transfer_ctrl (
    .clk_dc_g     (clk_dc_g),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .start_req_i  (start_req),
    .cfg_fe_req_i (cfg_fe_req),
    .cfg_fe_rsp_o (cfg_fe_rsp),
    .tfr_idle_o   (tfr_idle),
    .fe_req_o     (fe_req_o),
    .fe_rsp_i     (fe_rsp_i),
    .start_o      (start_o),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .tfr_error_o  (tfr_error)
  );

  assign error_o = wr_error | tfr_error;  // Both sources share one status line.

endmodule

/* tb_clk_gen.sv */
// Free-running 4 ns clock; reset is held low for the first 16 rising edges.
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;                   // 4 ns period.
  end

  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;                               // Released away from the active edge.
  end

endmodule

/* dma_xif_props.sv */
// Checks hold only outside reset and clear; a cleared request may drop without ready.
`timescale 1ns/1ns

module dma_xif_props (
  input logic                 clk_dc_g,
  input logic                 rst_ni,
  input logic                 clear_i,
  input dma_xif_pkg::fe_req_t fe_req_i,
  input dma_xif_pkg::fe_rsp_t fe_rsp_i,
  input logic                 start_i,
  input logic                 busy_i,
  input logic                 done_i
);

  // A stalled request keeps every field until the front end takes it.
  assert property (@(posedge clk_dc_g) disable iff (!rst_ni || clear_i)
    fe_req_i.valid && !fe_rsp_i.ready |=> $stable(fe_req_i))
    else $error("Register port request changed while stalled.");

  assert property (@(posedge clk_dc_g) disable iff (!rst_ni)
    $onehot0({start_i, busy_i, done_i}))
    else $error("More than one transfer status output is high.");

  assert property (@(posedge clk_dc_g) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("Done status lasted longer than one cycle.");

endmodule

bind dma_xif_decoder_top dma_xif_props i_props (
  .clk_dc_g (clk_dc_g),
  .rst_ni   (rst_ni),
  .clear_i  (clear_i),
  .fe_req_i (fe_req_o),
  .fe_rsp_i (fe_rsp_i),
  .start_i  (start_o),
  .busy_i   (busy_o),
  .done_i   (done_o)
);

/* tb_dma_xif.sv */
// Directed tests with a random-latency front-end model; transfers start only with no write pending.
`timescale 1ns/1ns

module tb_dma_xif;

  logic                    clk;
  logic                    rst_n;
  logic                    clear;
  logic                    issue_valid;
  dma_xif_pkg::issue_req_t issue_req;
  logic                    issue_ready;
  logic                    issue_accept;
  dma_xif_pkg::fe_req_t    fe_req;
  dma_xif_pkg::fe_rsp_t    fe_rsp;
  logic                    start_s;
  logic                    busy_s;
  logic                    done_s;
  logic                    error_s;

  dma_xif_pkg::fe_req_t wlog [$];                // Every write the model answered.
  logic [31:0]          done_ids [$];
  logic [31:0]          next_id_val;
  logic                 fail_next_write;
  logic                 accept_seen;             // Accept level seen with the last issue.
  logic [15:0]          lfsr_q;
  int                   wait_cnt;
  bit                   armed;
  int                   err_cnt;
  int                   done_cnt;
  int                   last_status;
  int                   status_seq [$];
  int                   errors;
  int                   tests;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dma_xif_decoder_top i_dut (
    .clk_dc_g       (clk),
    .rst_ni         (rst_n),
    .clear_i        (clear),
    .issue_valid_i  (issue_valid),
    .issue_req_i    (issue_req),
    .issue_ready_o  (issue_ready),
    .issue_accept_o (issue_accept),
    .fe_req_o       (fe_req),
    .fe_rsp_i       (fe_rsp),
    .start_o        (start_s),
    .busy_o         (busy_s),
    .done_o         (done_s),
    .error_o        (error_s)
  );

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] make_instr(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [12:0] conf);
    logic [31:0] instr;
    instr        = '0;
    instr[6:0]   = opc;
    instr[14:12] = f3;
    instr[27:15] = conf;
    return instr;
  endfunction

  function automatic dma_xif_pkg::fe_req_t exp_write(input int idx, input logic [31:0] data);
    dma_xif_pkg::fe_req_t r;
    r.addr  = dma_xif_pkg::FE_ADDR[idx];
    r.write = 1'b1;
    r.wdata = data;
    r.wstrb = '1;
    r.valid = 1'b1;
    return r;
  endfunction

  // Front-end model, answers on the falling edge so ready is seen at the next rising edge.
  always @(negedge clk) begin
    if (!rst_n) begin
      fe_rsp = '0;
      armed  = 1'b0;
    end else if (fe_rsp.ready) begin
      fe_rsp = '0;
    end else if (fe_req.valid) begin
      if (!armed) begin
        wait_cnt = int'(rand_bits(2));           // 0 to 3 cycles of stall.
        armed    = 1'b1;
      end
      if (wait_cnt == 0) begin
        armed        = 1'b0;
        fe_rsp.ready = 1'b1;
        if (fe_req.write) begin
          fe_rsp.error    = fail_next_write;
          fail_next_write = 1'b0;
          wlog.push_back(fe_req);
        end else if (fe_req.addr == dma_xif_pkg::FE_NEXT_ID_ADDR) begin
          fe_rsp.rdata = next_id_val;
        end else if (fe_req.addr == dma_xif_pkg::FE_DONE_ID_ADDR) begin
          fe_rsp.rdata = (done_ids.size() > 0) ? done_ids.pop_front() : '0;
        end
      end else begin
        wait_cnt--;
      end
    end
  end

  // Status is sampled mid-cycle, after the model has set the response.
  always @(negedge clk) begin
    int cur;
    #1;
    if (rst_n) begin
      if (error_s) err_cnt++;
      if (done_s) done_cnt++;
      cur = start_s ? 1 : busy_s ? 2 : done_s ? 3 : 0;
      if (cur != 0 && cur != last_status) status_seq.push_back(cur);
      last_status = cur;
    end
  end

  task automatic check_fe_req(input string name, input dma_xif_pkg::fe_req_t exp,
                              input dma_xif_pkg::fe_req_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // Called on a falling edge; holds the instruction for exactly one cycle.
  task automatic issue(input logic [31:0] instr, input logic [31:0] r2, input logic [31:0] r1,
                       input logic [31:0] r0, input logic rv, output logic rdy);
    issue_valid = 1'b1;
    issue_req   = '{instr: instr, rs: {r2, r1, r0}, rs_valid: rv};
    #1;
    rdy         = issue_ready;
    accept_seen = issue_accept;
    @(negedge clk);
    issue_valid = 1'b0;
    issue_req   = '0;
  endtask

  task automatic wait_writes(input string name, input int n);
    int cyc;
    cyc = 0;
    while (wlog.size() < n && cyc < 200) begin
      @(negedge clk);
      cyc++;
    end
    if (wlog.size() < n) begin
      $display("%s: timed out waiting for write number %0d", name, n);
      errors++;
    end
  endtask

  // which is 0 for the done count and 1 for the error count.
  task automatic wait_status(input string name, input int which, input int target);
    int cyc;
    cyc = 0;
    while ((which == 0 ? done_cnt : err_cnt) < target && cyc < 300) begin
      @(negedge clk);
      cyc++;
    end
    if ((which == 0 ? done_cnt : err_cnt) < target) begin
      $display("%s: timed out waiting for %s", name, which == 0 ? "done" : "error");
      errors++;
    end
  endtask

  task automatic report(input string name, input int e0);
    tests++;
    $display("%s: finished with %0d mismatches", name, errors - e0);
  endtask

  task automatic test_configure();
    logic [12:0] conf;
    logic        rdy;
    int          e0;
    e0   = errors;
    conf = 13'(rand_bits(13));
    wlog.delete();
    issue(make_instr(dma_xif_pkg::CONF_OPCODE, dma_xif_pkg::CONF_FUNC3, conf), 0, 0, 0, 1, rdy);
    check_bit("configure ready", 1'b1, rdy);
    check_bit("configure accept", 1'b1, accept_seen);
    wait_writes("configure", 1);
    repeat (20) @(negedge clk);
    check_bit("configure single write", 1'b1, wlog.size() == 1);
    if (wlog.size() > 0) check_fe_req("configure write", exp_write(0, {19'b0, conf}), wlog[0]);
    issue(make_instr(dma_xif_pkg::CONF_OPCODE, 3'b010, conf), 0, 0, 0, 1, rdy);
    check_bit("wrong func3 ready", 1'b0, rdy);
    check_bit("wrong func3 accept", 1'b0, accept_seen);
    repeat (20) @(negedge clk);
    check_bit("wrong func3 no write", 1'b1, wlog.size() == 1);
    report("configure", e0);
  endtask

  task automatic test_addr_len();
    logic [31:0] dst;
    logic [31:0] src;
    logic [31:0] len;
    logic        rdy;
    int          e0;
    e0  = errors;
    dst = rand_bits(32);
    src = rand_bits(32);
    len = rand_bits(32);
    wlog.delete();
    issue(make_instr(dma_xif_pkg::SET_OPCODE, dma_xif_pkg::SET_AL_FUNC3, 0), dst, src, len, 1,
          rdy);
    wait_writes("address length", 3);
    if (wlog.size() == 3) begin
      check_fe_req("dst write", exp_write(dma_xif_pkg::IDX_DST_ADDR, dst), wlog[0]);
      check_fe_req("src write", exp_write(dma_xif_pkg::IDX_SRC_ADDR, src), wlog[1]);
      check_fe_req("len write", exp_write(dma_xif_pkg::IDX_LENGTH, len), wlog[2]);
    end
    report("address length", e0);
  endtask

  task automatic test_priority();
    logic [12:0] conf;
    logic        rdy;
    int          e0;
    e0   = errors;
    conf = 13'(rand_bits(13));
    wlog.delete();
    issue(make_instr(dma_xif_pkg::SET_OPCODE, dma_xif_pkg::SET_SR2_FUNC3, 0),
          32'h40, 32'h80, 32'h3, 1, rdy);
    issue(make_instr(dma_xif_pkg::CONF_OPCODE, dma_xif_pkg::CONF_FUNC3, conf), 0, 0, 0, 1, rdy);
    wait_writes("priority", 4);
    if (wlog.size() == 4) begin
      check_fe_req("prio conf", exp_write(dma_xif_pkg::IDX_CONF, {19'b0, conf}), wlog[0]);
      check_fe_req("prio dst stride", exp_write(dma_xif_pkg::IDX_DST_STRIDE_2, 32'h40), wlog[1]);
      check_fe_req("prio src stride", exp_write(dma_xif_pkg::IDX_SRC_STRIDE_2, 32'h80), wlog[2]);
      check_fe_req("prio reps", exp_write(dma_xif_pkg::IDX_REPS_2, 32'h3), wlog[3]);
    end
    report("priority", e0);
  endtask

  task automatic test_transfer();
    logic rdy;
    int   d0;
    int   e0;
    int   er0;
    e0          = errors;
    d0          = done_cnt;
    er0         = err_cnt;
    next_id_val = 32'd5;
    done_ids    = '{32'd3, 32'd4, 32'd5};
    status_seq.delete();
    issue(make_instr(dma_xif_pkg::SET_OPCODE, dma_xif_pkg::SET_S_FUNC3, 0), 0, 0, 0, 1, rdy);
    wait_status("transfer", 0, d0 + 1);
    repeat (10) @(negedge clk);
    check_bit("transfer single done", 1'b1, done_cnt == d0 + 1);
    check_bit("transfer no error", 1'b1, err_cnt == er0);
    check_bit("transfer order", 1'b1,
              status_seq.size() == 3 && status_seq[0] == 1 && status_seq[1] == 2 &&
              status_seq[2] == 3);
    report("transfer", e0);
  endtask

  task automatic test_errors();
    logic rdy;
    int   d0;
    int   e0;
    int   er0;
    e0          = errors;
    d0          = done_cnt;
    er0         = err_cnt;
    next_id_val = 32'd0;
    issue(make_instr(dma_xif_pkg::SET_OPCODE, dma_xif_pkg::SET_S_FUNC3, 0), 0, 0, 0, 1, rdy);
    wait_status("zero id", 1, er0 + 1);
    repeat (10) @(negedge clk);
    check_bit("zero id no done", 1'b1, done_cnt == d0);
    next_id_val = 32'd7;
    done_ids    = '{32'd7};
    issue(make_instr(dma_xif_pkg::SET_OPCODE, dma_xif_pkg::SET_S_FUNC3, 0), 0, 0, 0, 1, rdy);
    wait_status("restart", 0, d0 + 1);
    repeat (5) @(negedge clk);
    er0             = err_cnt;
    fail_next_write = 1'b1;
    wlog.delete();
    issue(make_instr(dma_xif_pkg::CONF_OPCODE, dma_xif_pkg::CONF_FUNC3, 13'h1a5), 0, 0, 0, 1,
          rdy);
    wait_writes("write retry", 2);
    check_bit("write error flagged", 1'b1, err_cnt == er0 + 1);
    if (wlog.size() == 2) begin
      check_fe_req("failed write", exp_write(dma_xif_pkg::IDX_CONF, 32'h1a5), wlog[0]);
      check_fe_req("retried write", exp_write(dma_xif_pkg::IDX_CONF, 32'h1a5), wlog[1]);
    end
    report("errors", e0);
  endtask

  task automatic test_clear();
    logic rdy;
    int   e0;
    int   n0;
    e0 = errors;
    wlog.delete();
    issue(make_instr(dma_xif_pkg::SET_OPCODE, dma_xif_pkg::SET_AL_FUNC3, 0), 1, 2, 3, 1, rdy);
    clear = 1'b1;                                // Seen on the edge right after the loads.
    @(negedge clk);
    clear = 1'b0;
    @(negedge clk);
    n0 = wlog.size();
    repeat (30) @(negedge clk);
    check_bit("clear no writes", 1'b1, wlog.size() == n0);
    check_bit("clear request idle", 1'b0, fe_req.valid);
    report("clear", e0);
  endtask

  initial begin
    int cyc;
    clear           = 1'b0;
    issue_valid     = 1'b0;
    issue_req       = '0;
    fe_rsp          = '0;
    next_id_val     = 32'd1;
    fail_next_write = 1'b0;
    lfsr_q          = 16'd18414;
    wait_cnt        = 0;
    armed           = 1'b0;
    err_cnt         = 0;
    done_cnt        = 0;
    last_status     = 0;
    errors          = 0;
    tests           = 0;
    cyc             = 0;
    while (rst_n !== 1'b1 && cyc < 100) begin
      @(negedge clk);
      cyc++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      errors++;
    end
    @(negedge clk);
    check_bit("reset ready", 1'b0, issue_ready);
    check_bit("reset request", 1'b0, fe_req.valid);
    test_configure();
    test_addr_len();
    test_priority();
    test_transfer();
    test_errors();
    test_clear();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
dma_xif_pkg.sv
dma_cmd_decoder.sv
dma_reg_configurer.sv
dma_transfer_ctrl.sv
dma_xif_decoder_top.sv
tb_clk_gen.sv
dma_xif_props.sv
tb_dma_xif.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_dma_xif -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Test passed$" \
  && echo "Simulation run succeeded" \
  || { echo "Simulation run unsuccessful"; exit 1; }
